//--- dp_consts.svh
`ifndef DP_CONSTS_SVH
`define DP_CONSTS_SVH

// --------------------------------------------------
// Datapath sizes
// --------------------------------------------------

// Width of every register and of the shared bus.
`define DP_WIDTH 32

// General purpose registers R0 to R15.
`define DP_NUM_GPR 16

// Low bits of IR holding the immediate (C) field.
`define DP_IMM_WIDTH 19

`endif

//--- dp_pkg.sv
`include "dp_consts.svh"

package dp_pkg;

	// --------------------------------------------------
	// ALU operations
	// --------------------------------------------------
	typedef enum logic [4:0] {
		OP_ADD  = 5'd0,
		OP_SUB  = 5'd1,
		OP_AND  = 5'd2,
		OP_OR   = 5'd3,
		OP_SHR  = 5'd4,
		OP_SHRA = 5'd5,
		OP_SHL  = 5'd6,
		OP_ROR  = 5'd7,
		OP_ROL  = 5'd8,
		OP_MUL  = 5'd9,
		OP_NEG  = 5'd10,
		OP_NOT  = 5'd11
	} alu_op_t;

	// --------------------------------------------------
	// Bus sources, lowest code has priority
	// --------------------------------------------------
	typedef enum logic [4:0] {
		SRC_R0, SRC_R1, SRC_R2, SRC_R3,
		SRC_R4, SRC_R5, SRC_R6, SRC_R7,
		SRC_R8, SRC_R9, SRC_R10, SRC_R11,
		SRC_R12, SRC_R13, SRC_R14, SRC_R15,
		SRC_HI, SRC_LO, SRC_ZHI, SRC_ZLO,
		SRC_PC, SRC_MDR, SRC_INPORT, SRC_CSIGN,
		SRC_NONE = 5'd31
	} bus_src_t;

	// One micro-step worth of strobes.
	typedef struct packed {
		logic [`DP_NUM_GPR-1:0] gpr_in;
		logic [`DP_NUM_GPR-1:0] gpr_out;
		logic pc_in;
		logic ir_in;
		logic mar_in;
		logic mdr_in;
		logic y_in;
		logic z_in;
		logic hi_in;
		logic lo_in;
		logic read;        // MDR takes memory data instead of the bus.
		logic inc_pc;      // PC loads from the ALU, ALU forces b + 1.
		logic ba_out;      // R0 reads as zero for base addressing.
		logic hi_out;
		logic lo_out;
		logic z_high_out;
		logic z_low_out;
		logic pc_out;
		logic mdr_out;
		logic in_port_out;
		logic c_out;
	} dp_ctrl_t;

	// Special register values that can reach the bus.
	typedef struct packed {
		logic [`DP_WIDTH-1:0] hi;
		logic [`DP_WIDTH-1:0] lo;
		logic [`DP_WIDTH-1:0] z_hi;
		logic [`DP_WIDTH-1:0] z_lo;
		logic [`DP_WIDTH-1:0] pc;
		logic [`DP_WIDTH-1:0] mdr;
		logic [`DP_WIDTH-1:0] ir;
	} bus_sources_t;

endpackage

//--- gpr_file.sv
`include "dp_consts.svh"

module gpr_file import dp_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  dp_ctrl_t ctrl,
	input  logic [`DP_WIDTH-1:0] bus,
	output logic [`DP_NUM_GPR-1:0][`DP_WIDTH-1:0] gpr_values
);

	logic [`DP_NUM_GPR-1:0][`DP_WIDTH-1:0] regs;

	// --------------------------------------------------
	// Register storage
	// --------------------------------------------------
	// Several registers may load in the same cycle; they all see the same bus word.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			regs <= '0;
		end else begin
			for (int i = 0; i < `DP_NUM_GPR; i++) begin
				if (ctrl.gpr_in[i]) begin
					regs[i] <= bus;
				end
			end
		end
	end

	// --------------------------------------------------
	// Read side
	// --------------------------------------------------
	// R0 is hidden while BAout is high so that a base of R0 means absolute zero.
	always_comb begin
		gpr_values = regs;
		if (ctrl.ba_out) begin
			gpr_values[0] = '0;
		end
	end

endmodule

//--- special_regs.sv
`include "dp_consts.svh"

module special_regs import dp_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  dp_ctrl_t ctrl,
	input  logic [`DP_WIDTH-1:0] bus,
	input  logic [`DP_WIDTH-1:0] mdata_in,
	input  logic [2*`DP_WIDTH-1:0] z_result,
	output bus_sources_t srcs,
	output logic [`DP_WIDTH-1:0] y,
	output logic [`DP_WIDTH-1:0] mar
);

	logic [`DP_WIDTH-1:0] pc;
	logic [`DP_WIDTH-1:0] ir;
	logic [`DP_WIDTH-1:0] mdr;
	logic [`DP_WIDTH-1:0] hi;
	logic [`DP_WIDTH-1:0] lo;
	logic [`DP_WIDTH-1:0] z_hi;
	logic [`DP_WIDTH-1:0] z_lo;
	logic [`DP_WIDTH-1:0] pc_next;
	logic [`DP_WIDTH-1:0] mdr_next;

	// --------------------------------------------------
	// Input selects
	// --------------------------------------------------
	assign pc_next  = ctrl.inc_pc ? z_result[`DP_WIDTH-1:0] : bus; // Increment comes back via the ALU.
	assign mdr_next = ctrl.read ? mdata_in : bus;

	// --------------------------------------------------
	// Registers
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc   <= '0;
			ir   <= '0;
			mar  <= '0;
			mdr  <= '0;
			hi   <= '0;
			lo   <= '0;
			y    <= '0;
			z_hi <= '0;
			z_lo <= '0;
		end else begin
			if (ctrl.pc_in)  pc  <= pc_next;
			if (ctrl.ir_in)  ir  <= bus;
			if (ctrl.mar_in) mar <= bus;
			if (ctrl.mdr_in) mdr <= mdr_next;
			if (ctrl.hi_in)  hi  <= bus;
			if (ctrl.lo_in)  lo  <= bus;
			if (ctrl.y_in)   y   <= bus;
			if (ctrl.z_in) begin
				z_hi <= z_result[2*`DP_WIDTH-1:`DP_WIDTH]; // Z is always written as a pair.
				z_lo <= z_result[`DP_WIDTH-1:0];
			end
		end
	end

	// Y only feeds the ALU and MAR only feeds memory, so neither goes in srcs.
	always_comb begin
		srcs.hi   = hi;
		srcs.lo   = lo;
		srcs.z_hi = z_hi;
		srcs.z_lo = z_lo;
		srcs.pc   = pc;
		srcs.mdr  = mdr;
		srcs.ir   = ir;
	end

endmodule

//--- bus_select.sv
`include "dp_consts.svh"

module bus_select import dp_pkg::*; (
	input  dp_ctrl_t ctrl,
	input  logic [`DP_NUM_GPR-1:0][`DP_WIDTH-1:0] gpr_values,
	input  bus_sources_t srcs,
	input  logic [`DP_WIDTH-1:0] in_port,
	output logic [`DP_WIDTH-1:0] bus
);

	localparam int NUM_REQ = `DP_NUM_GPR + 8;

	logic [NUM_REQ-1:0] req;
	bus_src_t sel;
	logic [`DP_WIDTH-1:0] imm_ext;

	// --------------------------------------------------
	// Priority encoder
	// --------------------------------------------------
	// Bit positions line up with the bus_src_t codes.
	assign req = {ctrl.c_out, ctrl.in_port_out, ctrl.mdr_out, ctrl.pc_out,
		ctrl.z_low_out, ctrl.z_high_out, ctrl.lo_out, ctrl.hi_out, ctrl.gpr_out};

	// Scanning from the top lets the lowest active request win.
	always_comb begin
		sel = SRC_NONE;
		for (int i = NUM_REQ - 1; i >= 0; i--) begin
			if (req[i]) begin
				sel = bus_src_t'(5'(i));
			end
		end
	end

	// Immediate field of IR, sign-extended to full width.
	assign imm_ext = {{(`DP_WIDTH - `DP_IMM_WIDTH){srcs.ir[`DP_IMM_WIDTH-1]}},
		srcs.ir[`DP_IMM_WIDTH-1:0]};

	// --------------------------------------------------
	// 32-way bus multiplexer
	// --------------------------------------------------
	always_comb begin
		case (sel)
			SRC_HI:     bus = srcs.hi;
			SRC_LO:     bus = srcs.lo;
			SRC_ZHI:    bus = srcs.z_hi;
			SRC_ZLO:    bus = srcs.z_lo;
			SRC_PC:     bus = srcs.pc;
			SRC_MDR:    bus = srcs.mdr;
			SRC_INPORT: bus = in_port;
			SRC_CSIGN:  bus = imm_ext;
			SRC_NONE:   bus = '0;     // Idle bus reads zero.
			default:    bus = gpr_values[4'(sel)]; // Codes 0 to 15 are R0 to R15.
		endcase
	end

endmodule

//--- alu.sv
`include "dp_consts.svh"

module alu import dp_pkg::*; (
	input  alu_op_t opcode,
	input  logic inc_pc,
	input  logic [`DP_WIDTH-1:0] a,
	input  logic [`DP_WIDTH-1:0] b,
	output logic [2*`DP_WIDTH-1:0] result
);

	logic [4:0] shamt;
	logic [2*`DP_WIDTH-1:0] a_twice;
	logic [2*`DP_WIDTH-1:0] ror_wide;
	logic [2*`DP_WIDTH-1:0] rol_wide;
	logic [`DP_WIDTH-1:0] sra;
	logic signed [2*`DP_WIDTH-1:0] product;

	// --------------------------------------------------
	// Shared terms
	// --------------------------------------------------
	assign shamt = b[4:0]; // Only the low five bits of the bus give the amount.

	// Rotates are shifts of a doubled copy of a.
	assign a_twice  = {a, a};
	assign ror_wide = a_twice >> shamt;
	assign rol_wide = a_twice << shamt;

	assign sra = $signed(a) >>> shamt;

	// Full signed product, both halves are kept in Z.
	assign product = $signed(a) * $signed(b);

	// --------------------------------------------------
	// Operation select
	// --------------------------------------------------
	always_comb begin
		result = '0;
		if (inc_pc) begin
			result[`DP_WIDTH-1:0] = b + 1'b1; // PC sits on the bus during the increment.
		end else begin
			case (opcode)
				OP_ADD:  result[`DP_WIDTH-1:0] = a + b;
				OP_SUB:  result[`DP_WIDTH-1:0] = a - b;
				OP_AND:  result[`DP_WIDTH-1:0] = a & b;
				OP_OR:   result[`DP_WIDTH-1:0] = a | b;
				OP_SHR:  result[`DP_WIDTH-1:0] = a >> shamt;
				OP_SHRA: result[`DP_WIDTH-1:0] = sra;
				OP_SHL:  result[`DP_WIDTH-1:0] = a << shamt;
				OP_ROR:  result[`DP_WIDTH-1:0] = ror_wide[`DP_WIDTH-1:0];
				OP_ROL:  result[`DP_WIDTH-1:0] = rol_wide[2*`DP_WIDTH-1:`DP_WIDTH];
				OP_MUL:  result = product;
				OP_NEG:  result[`DP_WIDTH-1:0] = -b;
				OP_NOT:  result[`DP_WIDTH-1:0] = ~b;
				default: result = '0;
			endcase
		end
	end

endmodule

//--- datapath.sv
`include "dp_consts.svh"

module datapath import dp_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  dp_ctrl_t ctrl,
	input  alu_op_t opcode,
	input  logic [`DP_WIDTH-1:0] mdata_in,
	input  logic [`DP_WIDTH-1:0] in_port,
	output logic [`DP_WIDTH-1:0] bus,
	output logic [`DP_WIDTH-1:0] mar,
	output logic [`DP_WIDTH-1:0] ir
);

	logic [`DP_NUM_GPR-1:0][`DP_WIDTH-1:0] gpr_values;
	bus_sources_t srcs;
	logic [`DP_WIDTH-1:0] y;
	logic [2*`DP_WIDTH-1:0] z_result;

	// --------------------------------------------------
	// Storage
	// --------------------------------------------------
	gpr_file gpr_file_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.ctrl       (ctrl),
		.bus        (bus),
		.gpr_values (gpr_values)
	);

	special_regs special_regs_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.ctrl     (ctrl),
		.bus      (bus),
		.mdata_in (mdata_in),
		.z_result (z_result),
		.srcs     (srcs),
		.y        (y),
		.mar      (mar)
	);

	// --------------------------------------------------
	// Bus and ALU
	// --------------------------------------------------
	bus_select bus_select_inst (
		.ctrl       (ctrl),
		.gpr_values (gpr_values),
		.srcs       (srcs),
		.in_port    (in_port),
		.bus        (bus)
	);

	alu alu_inst (
		.opcode (opcode),
		.inc_pc (ctrl.inc_pc),
		.a      (y),
		.b      (bus),
		.result (z_result)
	);

	assign ir = srcs.ir; // Brought out for the control unit to decode.

endmodule

//--- datapath_asserts.sv
`include "dp_consts.svh"

module datapath_asserts import dp_pkg::*; (
	input logic clk,
	input logic rst_n,
	input dp_ctrl_t ctrl,
	input alu_op_t opcode,
	input logic [`DP_WIDTH-1:0] bus,
	input logic [`DP_WIDTH-1:0] mar,
	input bus_sources_t srcs
);

	timeunit 1ns;
	timeprecision 100ps;

	logic any_out;
	int fail_count = 0;

	assign any_out = (|ctrl.gpr_out) | ctrl.hi_out | ctrl.lo_out | ctrl.z_high_out
		| ctrl.z_low_out | ctrl.pc_out | ctrl.mdr_out | ctrl.in_port_out | ctrl.c_out;

	// --------------------------------------------------
	// Bus and register properties
	// --------------------------------------------------
	idle_bus_zero: assert property (@(posedge clk) disable iff (!rst_n)
		!any_out |-> bus == '0)
		else begin
			fail_count++;
			$error("bus is not zero with no source enabled");
		end

	// A reset edge clears MAR before anything can load it again.
	mar_cleared: assert property (@(posedge clk) !rst_n |=> mar == '0)
		else begin
			fail_count++;
			$error("mar is not zero in the cycle after reset");
		end

	z_high_clear: assert property (@(posedge clk) disable iff (!rst_n)
		ctrl.z_in && (ctrl.inc_pc || opcode != OP_MUL) |=> srcs.z_hi == '0)
		else begin
			fail_count++;
			$error("z_hi is not zero after a load of Z by an operation other than MUL");
		end

endmodule

// Attach the checks to every datapath instance.
bind datapath datapath_asserts datapath_asserts_inst (
	.clk    (clk),
	.rst_n  (rst_n),
	.ctrl   (ctrl),
	.opcode (opcode),
	.bus    (bus),
	.mar    (mar),
	.srcs   (srcs)
);

//--- datapath_tb.sv
`include "dp_consts.svh"

module datapath_tb import dp_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int ROWS = 36;
	localparam int RESET_TIMEOUT = 40;

	typedef struct packed {
		alu_op_t op;
		logic [`DP_WIDTH-1:0] a;
		logic [`DP_WIDTH-1:0] b;
		logic [`DP_WIDTH-1:0] exp_hi;
		logic [`DP_WIDTH-1:0] exp_lo;
	} op_row_t;

	logic clk;
	logic rst_n;
	dp_ctrl_t ctrl;
	alu_op_t opcode;
	logic [`DP_WIDTH-1:0] mdata_in;
	logic [`DP_WIDTH-1:0] in_port;
	logic [`DP_WIDTH-1:0] bus;
	logic [`DP_WIDTH-1:0] mar;
	logic [`DP_WIDTH-1:0] ir;

	op_row_t op_table [ROWS];
	logic [31:0] lfsr_state = 32'ha261_9e2b;
	logic [`DP_WIDTH-1:0] step_bus;
	int checks = 0;
	int value_errors = 0;
	int other_errors = 0;

	datapath datapath_inst (
		.clk      (clk),
		.rst_n    (rst_n),
		.ctrl     (ctrl),
		.opcode   (opcode),
		.mdata_in (mdata_in),
		.in_port  (in_port),
		.bus      (bus),
		.mar      (mar),
		.ir       (ir)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	initial begin
		rst_n = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

	// --------------------------------------------------
	// Random numbers and the reference model
	// --------------------------------------------------
	// Taps 32, 22, 2, 1 give a maximal length sequence.
	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] next_random(int nbits);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < nbits; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
		return value;
	endfunction

	function automatic logic [63:0] alu_model(alu_op_t op, logic [31:0] a, logic [31:0] b);
		int amt;
		longint sa;
		longint sb;
		logic [63:0] r;
		amt = b[4:0];
		sa = $signed(a);
		sb = $signed(b);
		r = '0;
		case (op)
			OP_ADD: r[31:0] = a + b;
			OP_SUB: r[31:0] = a + ~b + 32'd1;
			OP_AND: r[31:0] = a & b;
			OP_OR:  r[31:0] = a | b;
			OP_MUL: r = sa * sb;
			OP_NEG: r[31:0] = ~b + 32'd1;
			OP_NOT: r[31:0] = ~b;
			default: begin
				// Shifts and rotates are built one result bit at a time.
				for (int i = 0; i < 32; i++) begin
					case (op)
						OP_SHR:  r[i] = (i + amt < 32) ? a[i + amt] : 1'b0;
						OP_SHRA: r[i] = (i + amt < 32) ? a[i + amt] : a[31];
						OP_SHL:  r[i] = (i >= amt) ? a[i - amt] : 1'b0;
						OP_ROR:  r[i] = a[(i + amt) % 32];
						OP_ROL:  r[i] = a[(i + 32 - amt) % 32];
						default: r[i] = 1'b0;
					endcase
				end
			end
		endcase
		return r;
	endfunction

	// --------------------------------------------------
	// Checks and run control
	// --------------------------------------------------
	task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			value_errors++;
			$display("error %s: got 0x%08h, expected 0x%08h", name, got, exp);
		end
	endtask

	task automatic finish_run();
		int assert_errors;
		assert_errors = datapath_inst.datapath_asserts_inst.fail_count;
		$display("checks %0d, value errors %0d, other errors %0d, assertion errors %0d",
			checks, value_errors, other_errors, assert_errors);
		if (value_errors == 0 && other_errors == 0 && assert_errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	endtask

	task automatic wait_reset_release();
		int n;
		for (n = 0; n < RESET_TIMEOUT && rst_n !== 1'b1; n++) begin
			@(posedge clk);
		end
		if (rst_n !== 1'b1) begin
			other_errors++;
			$display("reset was never released within %0d clock cycles", RESET_TIMEOUT);
			finish_run();
		end
		@(negedge clk);
	endtask

	// --------------------------------------------------
	// Micro-steps that each start on a falling edge
	// --------------------------------------------------
	task automatic apply_step(dp_ctrl_t c);
		ctrl = c;
		#1;
		step_bus = bus; // Settled well before the rising edge.
		@(negedge clk);
		ctrl = '0;
	endtask

	task automatic expect_bus(dp_ctrl_t c, string name, logic [31:0] exp);
		apply_step(c);
		check_value(name, step_bus, exp);
	endtask

	task automatic load_mdr(logic [31:0] data);
		dp_ctrl_t c;
		c = '0;
		mdata_in = data;
		c.read = 1'b1;
		c.mdr_in = 1'b1;
		apply_step(c);
	endtask

	task automatic mem_to_reg(int r, logic [31:0] data);
		dp_ctrl_t c;
		c = '0;
		load_mdr(data);
		c.mdr_out = 1'b1;
		c.gpr_in[r] = 1'b1;
		apply_step(c);
	endtask

	task automatic check_gpr(int r, logic [31:0] exp);
		dp_ctrl_t c;
		c = '0;
		c.gpr_out[r] = 1'b1;
		expect_bus(c, $sformatf("bus (r%0d)", r), exp);
	endtask

	task automatic check_immediate(logic [31:0] word);
		dp_ctrl_t c;
		logic [31:0] exp;
		c = '0;
		exp = word[18] ? (word | 32'hfff8_0000) : (word & 32'h0007_ffff);
		load_mdr(word);
		c.mdr_out = 1'b1;
		c.ir_in = 1'b1;
		apply_step(c);
		check_value("ir", ir, word);
		c = '0;
		c.c_out = 1'b1;
		expect_bus(c, "bus (C sign-extended)", exp);
	endtask

	task automatic run_row(int i);
		dp_ctrl_t c;
		int ra;
		int rb;
		ra = next_random(4);
		rb = ra ^ (next_random(4) % 15 + 1); // Never the same register as ra.
		opcode = op_table[i].op;
		mem_to_reg(ra, op_table[i].a);
		mem_to_reg(rb, op_table[i].b);
		c = '0;
		c.gpr_out[ra] = 1'b1;
		c.y_in = 1'b1;
		apply_step(c);
		c = '0;
		c.gpr_out[rb] = 1'b1;
		c.z_in = 1'b1;
		apply_step(c);
		c = '0;
		c.z_low_out = 1'b1;
		expect_bus(c, $sformatf("bus (Z low, row %0d, %s)", i, opcode.name()),
			op_table[i].exp_lo);
		c = '0;
		c.z_high_out = 1'b1;
		expect_bus(c, $sformatf("bus (Z high, row %0d, %s)", i, opcode.name()),
			op_table[i].exp_hi);
	endtask

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------
	initial begin
		dp_ctrl_t c;
		logic [31:0] v;
		logic [31:0] w;
		ctrl = '0;
		opcode = OP_ADD;
		mdata_in = '0;
		in_port = '0;
		for (int i = 0; i < ROWS; i++) begin
			op_table[i].op = alu_op_t'(5'(i % 12));
			op_table[i].a = next_random(32);
			op_table[i].b = next_random(32);
			{op_table[i].exp_hi, op_table[i].exp_lo} =
				alu_model(op_table[i].op, op_table[i].a, op_table[i].b);
		end
		wait_reset_release();

		check_value("bus", bus, '0);
		check_value("mar", mar, '0);
		check_value("ir", ir, '0);
		for (int r = 0; r < `DP_NUM_GPR; r++) check_gpr(r, '0);

		for (int i = 0; i < ROWS; i++) run_row(i);

		// PC increment goes through the ALU and back into PC.
		v = next_random(32);
		in_port = v;
		c = '0;
		c.in_port_out = 1'b1;
		c.pc_in = 1'b1;
		apply_step(c);
		c.in_port_out = 1'b0;
		c.pc_out = 1'b1;
		c.inc_pc = 1'b1;
		c.z_in = 1'b1;
		apply_step(c);
		c = '0;
		c.pc_out = 1'b1;
		expect_bus(c, "bus (PC after increment)", v + 32'd1);
		c = '0;
		c.z_low_out = 1'b1;
		expect_bus(c, "bus (Z low after increment)", v + 32'd1);
		w = next_random(32);
		in_port = w;
		c = '0;
		c.in_port_out = 1'b1;
		c.pc_in = 1'b1;
		apply_step(c);
		c = '0;
		c.pc_out = 1'b1;
		expect_bus(c, "bus (PC plain load)", w);

		// Priority between sources and R0 under BAout.
		v = next_random(32);
		w = next_random(32);
		mem_to_reg(3, v);
		mem_to_reg(7, w);
		c = '0;
		c.gpr_out[3] = 1'b1;
		c.gpr_out[7] = 1'b1;
		expect_bus(c, "bus (r3 over r7)", v);
		c = '0;
		c.gpr_out[7] = 1'b1;
		c.hi_out = 1'b1;
		expect_bus(c, "bus (r7 over hi)", w);
		v = next_random(32) | 32'd1;
		mem_to_reg(0, v);
		check_gpr(0, v);
		c = '0;
		c.gpr_out[0] = 1'b1;
		c.ba_out = 1'b1;
		expect_bus(c, "bus (r0 with ba_out)", '0);
		c.gpr_out[5] = 1'b1;
		expect_bus(c, "bus (r0 with ba_out over r5)", '0);

		// MAR capture and the IR immediate.
		v = next_random(32);
		in_port = v;
		c = '0;
		c.in_port_out = 1'b1;
		c.mar_in = 1'b1;
		apply_step(c);
		check_value("mar", mar, v);
		check_immediate(next_random(32) & 32'hfffb_ffff);
		check_immediate(next_random(32) | 32'h0004_0000);

		finish_run();
	end

endmodule

//--- sim.f
+incdir+.
dp_pkg.sv
gpr_file.sv
special_regs.sv
bus_select.sv
alu.sv
datapath.sv
datapath_asserts.sv
datapath_tb.sv
